/* hw/glb_pkg.sv */
// Global buffer package
// Sizes, port configuration, request structs and the bank-mapping functions
`default_nettype none

package glb_pkg;

    localparam int NUM_BANK   = 4;
    localparam int NUM_WR     = 2;
    localparam int NUM_RD     = 2;
    localparam int NUM_PORT   = 4;
    localparam int BANK_WIDTH = 32;
    localparam int BANK_WORDS = 16;
    localparam int BANK_AW    = 4;
    localparam int MAXPAR     = 2;
    localparam int PORT_WIDTH = 64;
    localparam int ADDR_W     = 8;

    typedef logic [NUM_BANK-1:0]         bank_mask_t;
    typedef logic [$clog2(NUM_BANK)-1:0] bank_idx_t;

    // Static per-port configuration with par of 1 or 2
    typedef struct packed {
        bank_mask_t bank_flag;
        logic [1:0] par;
    } port_cfg_t;

    typedef struct packed {
        logic [ADDR_W-1:0]     addr;
        logic [PORT_WIDTH-1:0] data;
    } wr_req_t;

    // Bank requests carry the running beat address next to the bank row
    typedef struct packed {
        logic [ADDR_W-1:0]     beat;
        logic [BANK_AW-1:0]    addr;
        logic [BANK_WIDTH-1:0] data;
    } bank_wr_t;

    typedef struct packed {
        logic [ADDR_W-1:0]  beat;
        logic [BANK_AW-1:0] addr;
    } bank_rd_t;

    // ==============================
    // Bank mapping
    // ==============================
    function automatic bank_idx_t first_bank(bank_mask_t flag);
        first_bank = '0;
        for (int i = NUM_BANK - 1; i >= 0; i--) begin
            if (flag[i]) first_bank = bank_idx_t'(i);
        end
    endfunction

    function automatic logic [$clog2(NUM_BANK):0] bank_count(bank_mask_t flag);
        bank_count = '0;
        for (int i = 0; i < NUM_BANK; i++) begin
            bank_count = bank_count + flag[i];
        end
    endfunction

    // Ring size in beats
    function automatic logic [ADDR_W-1:0] port_space(port_cfg_t cfg);
        if (cfg.par == 2'd0) return ADDR_W'(BANK_WORDS);
        return ADDR_W'(BANK_WORDS * int'(bank_count(cfg.bank_flag)) / int'(cfg.par));
    endfunction

    function automatic bank_idx_t cur_first_bank(port_cfg_t cfg, logic [ADDR_W-1:0] a);
        int unsigned grp;
        grp = (int'(a) % int'(port_space(cfg))) / BANK_WORDS;
        return bank_idx_t'(int'(first_bank(cfg.bank_flag)) + grp * int'(cfg.par));
    endfunction

    // Banks touched by the beat at address a
    function automatic bank_mask_t hit_mask(port_cfg_t cfg, logic [ADDR_W-1:0] a);
        int cur;
        cur = int'(cur_first_bank(cfg, a));
        hit_mask = '0;
        for (int b = 0; b < NUM_BANK; b++) begin
            hit_mask[b] = (b >= cur) && (b < cur + int'(cfg.par));
        end
    endfunction

endpackage

`default_nettype wire

/* hw/bank_sram.sv */
// Single-port SRAM bank
// Writes win the port, read data is registered and held until taken
`timescale 1ns/1ps
`default_nettype none

module bank_sram (
    input  wire logic                            clk,
    input  wire logic                            rst_n,
    input  wire logic                            wr_valid_i,
    input  wire glb_pkg::bank_wr_t               wr_i,
    input  wire logic                            rd_addr_valid_i,
    input  wire glb_pkg::bank_rd_t               rd_i,
    output logic                                 rd_addr_ready_o,
    output logic                                 rd_valid_o,
    input  wire logic                            rd_ready_i,
    output logic [glb_pkg::BANK_WIDTH-1:0]       rd_data_o
);
    import glb_pkg::*;

    logic [BANK_WIDTH-1:0] mem [BANK_WORDS];
    logic                  rd_fire;

    // No read while writing or while a result waits for the consumer
    assign rd_addr_ready_o = !wr_valid_i && (!rd_valid_o || rd_ready_i);
    assign rd_fire         = rd_addr_valid_i && rd_addr_ready_o;

    // ==============================
    // Array and read data
    // ==============================
    always_ff @(posedge clk) begin
        if (wr_valid_i) begin
            mem[wr_i.addr] <= wr_i.data;
        end
        if (rd_fire) begin
            rd_data_o <= mem[rd_i.addr];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid_o <= 1'b0;
        end else if (rd_fire) begin
            rd_valid_o <= 1'b1;
        end else if (rd_ready_i) begin
            rd_valid_o <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hw/bank_port_select.sv */
// Bank owner selection
// Muxes the owning write and read port onto one bank and tracks their progress
`timescale 1ns/1ps
`default_nettype none

module bank_port_select (
    input  wire logic                              clk,
    input  wire logic                              rst_n,
    input  wire glb_pkg::port_cfg_t                cfg_i [glb_pkg::NUM_PORT],
    input  wire glb_pkg::bank_idx_t                bank_idx_i,
    input  wire logic [glb_pkg::NUM_WR-1:0]        wr_valid_i,
    input  wire glb_pkg::bank_wr_t                 wr_i [glb_pkg::NUM_WR],
    input  wire logic [glb_pkg::NUM_RD-1:0]        rd_addr_valid_i,
    input  wire glb_pkg::bank_rd_t                 rd_i [glb_pkg::NUM_RD],
    input  wire logic [glb_pkg::NUM_RD-1:0]        rd_data_ready_i,
    output logic                                   bank_wr_valid_o,
    output glb_pkg::bank_wr_t                      bank_wr_o,
    output logic                                   bank_rd_valid_o,
    output logic [glb_pkg::BANK_WIDTH-1:0]         bank_rd_o,
    output logic                                   bank_rd_ready_o,
    output logic [glb_pkg::ADDR_W-1:0]             wr_next_o,
    output logic [glb_pkg::ADDR_W-1:0]             rd_next_o
);
    import glb_pkg::*;

    logic        wr_own;
    logic        rd_own;
    int unsigned wr_sel;
    int unsigned rd_sel;
    bank_rd_t    rd_req;
    logic        rd_req_valid;
    logic        rd_ready;

    // Lowest-numbered claiming port wins
    always_comb begin
        wr_own = 1'b0;
        wr_sel = 0;
        rd_own = 1'b0;
        rd_sel = 0;
        for (int p = NUM_WR - 1; p >= 0; p--) begin
            if (cfg_i[p].bank_flag[bank_idx_i]) begin
                wr_own = 1'b1;
                wr_sel = p;
            end
        end
        for (int r = NUM_RD - 1; r >= 0; r--) begin
            if (cfg_i[NUM_WR + r].bank_flag[bank_idx_i]) begin
                rd_own = 1'b1;
                rd_sel = r;
            end
        end
    end

    // Writes are always accepted
    assign bank_wr_valid_o = wr_own && wr_valid_i[wr_sel];
    assign bank_wr_o       = wr_i[wr_sel];
    assign rd_req_valid    = rd_own && rd_addr_valid_i[rd_sel];
    assign rd_req          = rd_i[rd_sel];
    assign rd_ready        = rd_own && rd_data_ready_i[rd_sel];

    bank_sram u_sram (
        .clk             (clk),
        .rst_n           (rst_n),
        .wr_valid_i      (bank_wr_valid_o),
        .wr_i            (bank_wr_o),
        .rd_addr_valid_i (rd_req_valid),
        .rd_i            (rd_req),
        .rd_addr_ready_o (bank_rd_ready_o),
        .rd_valid_o      (bank_rd_valid_o),
        .rd_ready_i      (rd_ready),
        .rd_data_o       (bank_rd_o)
    );

    // ==============================
    // Progress counters
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_next_o <= '0;
            rd_next_o <= '0;
        end else begin
            if (bank_wr_valid_o) begin
                wr_next_o <= bank_wr_o.beat + 1'b1;
            end
            if (rd_req_valid && bank_rd_ready_o) begin
                rd_next_o <= rd_req.beat + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/wr_port_ctrl.sv */
// Write port controller
// Spreads a beat over its banks and flags full against the reader
`timescale 1ns/1ps
`default_nettype none

module wr_port_ctrl (
    input  wire glb_pkg::port_cfg_t         cfg_i,
    input  wire logic                       wr_valid_i,
    input  wire glb_pkg::wr_req_t           wr_req_i,
    input  wire logic [glb_pkg::ADDR_W-1:0] rd_next_i [glb_pkg::NUM_BANK],
    output logic                            wr_ready_o,
    output logic                            wr_full_o,
    output glb_pkg::bank_mask_t             lane_valid_o,
    output glb_pkg::bank_wr_t               lane_o [glb_pkg::NUM_BANK]
);
    import glb_pkg::*;

    logic              configured;
    bank_idx_t         cur;
    bank_mask_t        hit;
    logic [ADDR_W-1:0] space;
    logic [ADDR_W-1:0] ahead;

    assign configured = |cfg_i.bank_flag;
    assign cur        = cur_first_bank(cfg_i, wr_req_i.addr);
    assign hit        = hit_mask(cfg_i, wr_req_i.addr);
    assign space      = port_space(cfg_i);

    // Distance to the reader as seen by the current first bank
    assign ahead     = wr_req_i.addr - rd_next_i[cur];
    assign wr_full_o = ahead >= space;

    assign wr_ready_o   = configured && !wr_full_o;
    assign lane_valid_o = hit & {NUM_BANK{wr_valid_i && wr_ready_o}};

    // ==============================
    // Lane steering
    // ==============================
    always_comb begin
        int unsigned k;
        for (int b = 0; b < NUM_BANK; b++) begin
            // Lane index of bank b inside the current group
            k = (b + NUM_BANK - int'(cur)) % MAXPAR;
            lane_o[b].beat = wr_req_i.addr;
            lane_o[b].addr = wr_req_i.addr[BANK_AW-1:0];
            lane_o[b].data = wr_req_i.data[k*BANK_WIDTH +: BANK_WIDTH];
        end
    end

endmodule

`default_nettype wire

/* hw/rd_port_ctrl.sv */
// Read port controller
// Issues addresses to its banks, flags empty and gathers the returned lanes
`timescale 1ns/1ps
`default_nettype none

module rd_port_ctrl (
    input  wire logic                            clk,
    input  wire logic                            rst_n,
    input  wire glb_pkg::port_cfg_t              cfg_i,
    input  wire logic                            rd_addr_valid_i,
    input  wire logic [glb_pkg::ADDR_W-1:0]      rd_addr_i,
    input  wire logic [glb_pkg::ADDR_W-1:0]      wr_next_i [glb_pkg::NUM_BANK],
    input  wire glb_pkg::bank_mask_t             bank_rd_ready_i,
    input  wire glb_pkg::bank_mask_t             bank_rd_valid_i,
    input  wire logic [glb_pkg::BANK_WIDTH-1:0]  bank_rd_data_i [glb_pkg::NUM_BANK],
    output logic                                 rd_addr_ready_o,
    output logic                                 rd_empty_o,
    output glb_pkg::bank_mask_t                  req_valid_o,
    output glb_pkg::bank_rd_t                    req_o [glb_pkg::NUM_BANK],
    output logic [glb_pkg::PORT_WIDTH-1:0]       rd_data_o,
    output logic                                 rd_data_valid_o
);
    import glb_pkg::*;

    logic       configured;
    bank_idx_t  cur;
    bank_mask_t hit;
    bank_idx_t  last_q;
    logic       prev_free;
    logic       issue;

    assign configured = |cfg_i.bank_flag;
    assign cur        = cur_first_bank(cfg_i, rd_addr_i);
    assign hit        = hit_mask(cfg_i, rd_addr_i);
    assign rd_empty_o = rd_addr_i >= wr_next_i[cur];

    // A result still held in the previous group blocks a move to a new group
    assign prev_free = !cfg_i.bank_flag[last_q] || bank_rd_ready_i[last_q];
    assign issue     = configured && !rd_empty_o && prev_free;

    assign rd_addr_ready_o = issue && bank_rd_ready_i[cur];
    assign req_valid_o     = hit & {NUM_BANK{rd_addr_valid_i && issue}};

    always_comb begin
        for (int b = 0; b < NUM_BANK; b++) begin
            req_o[b].beat = rd_addr_i;
            req_o[b].addr = rd_addr_i[BANK_AW-1:0];
        end
    end

    // ==============================
    // Outstanding read and gather
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_q <= '0;
        end else if (rd_addr_valid_i && rd_addr_ready_o) begin
            last_q <= cur;
        end
    end

    always_comb begin
        rd_data_o = '0;
        for (int k = 0; k < MAXPAR; k++) begin
            if (int'(last_q) + k < NUM_BANK) begin
                rd_data_o[k*BANK_WIDTH +: BANK_WIDTH] = bank_rd_data_i[int'(last_q) + k];
            end
        end
    end

    // Only a bank this port owns can hold its result
    assign rd_data_valid_o = cfg_i.bank_flag[last_q] && bank_rd_valid_i[last_q];

endmodule

`default_nettype wire

/* hw/glb_top.sv */
// Global buffer top
// Four shared banks behind two write ports and two read ports
`timescale 1ns/1ps
`default_nettype none

module glb_top (
    input  wire logic                            clk,
    input  wire logic                            rst_n,
    input  wire glb_pkg::port_cfg_t              cfg_i [glb_pkg::NUM_PORT],
    input  wire logic [glb_pkg::NUM_WR-1:0]      wr_valid_i,
    input  wire glb_pkg::wr_req_t                wr_req_i [glb_pkg::NUM_WR],
    output logic [glb_pkg::NUM_WR-1:0]           wr_ready_o,
    output logic [glb_pkg::NUM_WR-1:0]           wr_full_o,
    input  wire logic [glb_pkg::NUM_RD-1:0]      rd_addr_valid_i,
    input  wire logic [glb_pkg::ADDR_W-1:0]      rd_addr_i [glb_pkg::NUM_RD],
    output logic [glb_pkg::NUM_RD-1:0]           rd_addr_ready_o,
    output logic [glb_pkg::PORT_WIDTH-1:0]       rd_data_o [glb_pkg::NUM_RD],
    output logic [glb_pkg::NUM_RD-1:0]           rd_data_valid_o,
    input  wire logic [glb_pkg::NUM_RD-1:0]      rd_data_ready_i,
    output logic [glb_pkg::NUM_RD-1:0]           rd_empty_o
);
    import glb_pkg::*;

    // Port side, indexed [port][bank]
    bank_mask_t            lane_valid [NUM_WR];
    bank_wr_t              lane       [NUM_WR][NUM_BANK];
    bank_mask_t            req_valid  [NUM_RD];
    bank_rd_t              req        [NUM_RD][NUM_BANK];

    // Bank side
    logic [ADDR_W-1:0]     wr_next    [NUM_BANK];
    logic [ADDR_W-1:0]     rd_next    [NUM_BANK];
    bank_mask_t            bank_rd_ready;
    bank_mask_t            bank_rd_valid;
    logic [BANK_WIDTH-1:0] bank_rd_data [NUM_BANK];

    // ==============================
    // Banks
    // ==============================
    for (genvar b = 0; b < NUM_BANK; b++) begin : g_bank
        logic [NUM_WR-1:0] wv;
        bank_wr_t          wreq [NUM_WR];
        logic [NUM_RD-1:0] rv;
        bank_rd_t          rreq [NUM_RD];

        for (genvar p = 0; p < NUM_WR; p++) begin : g_wr
            assign wv[p]   = lane_valid[p][b];
            assign wreq[p] = lane[p][b];
        end
        for (genvar r = 0; r < NUM_RD; r++) begin : g_rd
            assign rv[r]   = req_valid[r][b];
            assign rreq[r] = req[r][b];
        end

        bank_port_select u_sel (
            .clk             (clk),
            .rst_n           (rst_n),
            .cfg_i           (cfg_i),
            .bank_idx_i      (bank_idx_t'(b)),
            .wr_valid_i      (wv),
            .wr_i            (wreq),
            .rd_addr_valid_i (rv),
            .rd_i            (rreq),
            .rd_data_ready_i (rd_data_ready_i),
            .bank_wr_valid_o (),
            .bank_wr_o       (),
            .bank_rd_valid_o (bank_rd_valid[b]),
            .bank_rd_o       (bank_rd_data[b]),
            .bank_rd_ready_o (bank_rd_ready[b]),
            .wr_next_o       (wr_next[b]),
            .rd_next_o       (rd_next[b])
        );
    end

    // ==============================
    // Ports
    // ==============================
    for (genvar p = 0; p < NUM_WR; p++) begin : g_wr_port
        wr_port_ctrl u_wr (
            .cfg_i        (cfg_i[p]),
            .wr_valid_i   (wr_valid_i[p]),
            .wr_req_i     (wr_req_i[p]),
            .rd_next_i    (rd_next),
            .wr_ready_o   (wr_ready_o[p]),
            .wr_full_o    (wr_full_o[p]),
            .lane_valid_o (lane_valid[p]),
            .lane_o       (lane[p])
        );
    end

    // Read ports follow the write ports in cfg_i
    for (genvar r = 0; r < NUM_RD; r++) begin : g_rd_port
        rd_port_ctrl u_rd (
            .clk             (clk),
            .rst_n           (rst_n),
            .cfg_i           (cfg_i[NUM_WR + r]),
            .rd_addr_valid_i (rd_addr_valid_i[r]),
            .rd_addr_i       (rd_addr_i[r]),
            .wr_next_i       (wr_next),
            .bank_rd_ready_i (bank_rd_ready),
            .bank_rd_valid_i (bank_rd_valid),
            .bank_rd_data_i  (bank_rd_data),
            .rd_addr_ready_o (rd_addr_ready_o[r]),
            .rd_empty_o      (rd_empty_o[r]),
            .req_valid_o     (req_valid[r]),
            .req_o           (req[r]),
            .rd_data_o       (rd_data_o[r]),
            .rd_data_valid_o (rd_data_valid_o[r])
        );
    end

endmodule

`default_nettype wire

/* testbench/tb_clk_gen.sv */
// Testbench clock and reset source
// 4 ns clock, active-low reset held for the first 4 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);
    initial begin
        clk_o   = 1'b0;
        rst_n_o = 1'b0;
        repeat (4) @(posedge clk_o);
        #1 rst_n_o = 1'b1;
    end

    always #2 clk_o = ~clk_o;

endmodule

`default_nettype wire

/* testbench/glb_tb.sv */
// Global buffer testbench
// Streams beats through both port pairs against a ring-buffer model
`timescale 1ns/1ps
`default_nettype none

module glb_tb;
    import glb_pkg::*;

    // Roughly 300 transactions at up to 4 cycles each with margin
    localparam int TIMEOUT_CYC = 5000;

    logic                  clk;
    logic                  rst_n;
    port_cfg_t             cfg_i [NUM_PORT];
    logic [NUM_WR-1:0]     wr_valid_i;
    wr_req_t               wr_req_i [NUM_WR];
    logic [NUM_WR-1:0]     wr_ready_o;
    logic [NUM_WR-1:0]     wr_full_o;
    logic [NUM_RD-1:0]     rd_addr_valid_i;
    logic [ADDR_W-1:0]     rd_addr_i [NUM_RD];
    logic [NUM_RD-1:0]     rd_addr_ready_o;
    logic [PORT_WIDTH-1:0] rd_data_o [NUM_RD];
    logic [NUM_RD-1:0]     rd_data_valid_o;
    logic [NUM_RD-1:0]     rd_data_ready_i;
    logic [NUM_RD-1:0]     rd_empty_o;

    int unsigned     cycles;
    int              errors;
    int              checks;
    string           test_name;
    int unsigned     wr_addr [NUM_WR];
    int unsigned     rd_addr [NUM_RD];
    logic [63:0]     model [NUM_WR][32];
    logic [63:0]     exp0 [$];
    logic [63:0]     exp1 [$];
    logic [63:0]     held [NUM_RD];
    logic            held_v [NUM_RD];
    logic            cfg_done;
    logic            rnd_ready;

    tb_clk_gen u_clk (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    glb_top UUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .cfg_i           (cfg_i),
        .wr_valid_i      (wr_valid_i),
        .wr_req_i        (wr_req_i),
        .wr_ready_o      (wr_ready_o),
        .wr_full_o       (wr_full_o),
        .rd_addr_valid_i (rd_addr_valid_i),
        .rd_addr_i       (rd_addr_i),
        .rd_addr_ready_o (rd_addr_ready_o),
        .rd_data_o       (rd_data_o),
        .rd_data_valid_o (rd_data_valid_o),
        .rd_data_ready_i (rd_data_ready_i),
        .rd_empty_o      (rd_empty_o)
    );

    // ==============================
    // Reference model
    // ==============================
    // Port 0 spreads a beat over two banks and port 1 chains its two banks
    function automatic int space_of(int p);
        return (p == 0) ? 16 : 32;
    endfunction

    // Lanes at or above par carry no defined data
    function automatic logic [63:0] lane_mask(int p);
        return (p == 0) ? 64'hffff_ffff_ffff_ffff : 64'h0000_0000_ffff_ffff;
    endfunction

    function automatic logic [63:0] expected_beat(int p, int unsigned a);
        return model[p][a % space_of(p)] & lane_mask(p);
    endfunction

    function automatic logic [63:0] rand64();
        return {$urandom, $urandom};
    endfunction

    // ==============================
    // Monitor and compare
    // ==============================
    task automatic check_data(int p);
        logic [63:0] got;
        logic [63:0] exp;
        int          pending;
        got = rd_data_o[p] & lane_mask(p);
        if (held_v[p]) begin
            assert (rd_data_valid_o[p] === 1'b1) else begin
                errors++;
                $display("Read port %0d dropped its data valid before the handshake", p);
            end
            assert (got === held[p]) else begin
                errors++;
                $display("ERR %s hold port %0d: expected %h, actual %h",
                         test_name, p, held[p], got);
            end
        end
        if (rd_data_valid_o[p] && rd_data_ready_i[p]) begin
            pending = (p == 0) ? exp0.size() : exp1.size();
            assert (pending != 0) else begin
                errors++;
                $display("Read port %0d returned data that was never requested", p);
            end
            if (pending != 0) begin
                exp = (p == 0) ? exp0.pop_front() : exp1.pop_front();
                checks++;
                assert (got === exp) else begin
                    errors++;
                    $display("ERR %s port %0d: expected %h, actual %h",
                             test_name, p, exp, got);
                end
            end
        end
    endtask

    always @(posedge clk) begin
        for (int p = 0; p < NUM_RD; p++) begin
            // Expected value fixed at the address handshake
            if (rd_addr_valid_i[p] && rd_addr_ready_o[p]) begin
                if (p == 0) exp0.push_back(expected_beat(p, rd_addr_i[p]));
                else        exp1.push_back(expected_beat(p, rd_addr_i[p]));
            end
            check_data(p);
            held_v[p] = rd_data_valid_o[p] && !rd_data_ready_i[p];
            held[p]   = rd_data_o[p] & lane_mask(p);
        end
        for (int p = 0; p < NUM_WR; p++) begin
            if (wr_valid_i[p] && wr_ready_o[p]) begin
                model[p][int'(wr_req_i[p].addr) % space_of(p)] = wr_req_i[p].data;
            end
        end
    end

    // Consumer ready is random only during the back-pressure test
    always @(posedge clk) begin
        #1;
        if (cfg_done) begin
            rd_data_ready_i = rnd_ready ? NUM_RD'($urandom % 4) : '1;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYC) begin
            $display("Timeout after %0d cycles, a handshake never completed", cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // ==============================
    // Drivers
    // ==============================
    task automatic write_beat(int p, logic [63:0] d);
        wr_req_i[p].addr = ADDR_W'(wr_addr[p]);
        wr_req_i[p].data = d;
        wr_valid_i[p]    = 1'b1;
        do @(posedge clk); while (!wr_ready_o[p]);
        #1;
        wr_valid_i[p]    = 1'b0;
        wr_addr[p]++;
        wr_req_i[p].addr = ADDR_W'(wr_addr[p]);
    endtask

    task automatic read_addr(int p);
        rd_addr_i[p]       = ADDR_W'(rd_addr[p]);
        rd_addr_valid_i[p] = 1'b1;
        do @(posedge clk); while (!rd_addr_ready_o[p]);
        #1;
        rd_addr_valid_i[p] = 1'b0;
        rd_addr[p]++;
        rd_addr_i[p]       = ADDR_W'(rd_addr[p]);
    endtask

    // Writer and reader of one pair run side by side
    task automatic stream(int p, int n);
        fork
            begin
                repeat (n) write_beat(p, rand64());
            end
            begin
                repeat (n) read_addr(p);
            end
        join
    endtask

    task automatic wait_drain();
        while (exp0.size() != 0 || exp1.size() != 0) @(posedge clk);
        @(posedge clk);
        #1;
    endtask

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        void'($urandom(14204));
        cycles          = 0;
        errors          = 0;
        checks          = 0;
        cfg_done        = 1'b0;
        rnd_ready       = 1'b0;
        wr_valid_i      = '0;
        rd_addr_valid_i = '0;
        rd_data_ready_i = '0;
        for (int i = 0; i < NUM_PORT; i++) cfg_i[i] = '0;
        for (int i = 0; i < NUM_WR; i++) begin
            wr_req_i[i] = '0;
            wr_addr[i]  = 0;
        end
        for (int i = 0; i < NUM_RD; i++) begin
            rd_addr_i[i] = '0;
            rd_addr[i]   = 0;
            held_v[i]    = 1'b0;
            held[i]      = '0;
        end

        test_name = "reset";
        @(posedge rst_n);
        @(posedge clk);
        assert ((wr_ready_o | rd_addr_ready_o | rd_data_valid_o) == '0) else begin
            errors++;
            $display("Ready or valid outputs are high before configuration");
        end
        #1;
        cfg_i[0] = '{bank_flag: 4'b0011, par: 2'd2};
        cfg_i[1] = '{bank_flag: 4'b1100, par: 2'd1};
        cfg_i[2] = '{bank_flag: 4'b0011, par: 2'd2};
        cfg_i[3] = '{bank_flag: 4'b1100, par: 2'd1};
        cfg_done = 1'b1;
        @(posedge clk);
        assert (rd_empty_o == 2'b11 && wr_full_o == 2'b00) else begin
            errors++;
            $display("Empty or full flags are wrong right after configuration");
        end
        #1;

        // Wraps the 16-beat ring twice
        test_name = "two_lane";
        stream(0, 40);
        wait_drain();

        // Crosses from bank 2 into bank 3 at address 16
        test_name = "one_lane";
        stream(1, 24);
        wait_drain();

        test_name = "full";
        while (wr_addr[0] - rd_addr[0] < 16) begin
            @(posedge clk);
            assert (!wr_full_o[0]) else begin
                errors++;
                $display("Write port 0 reports full %0d beats ahead",
                         wr_addr[0] - rd_addr[0]);
            end
            #1;
            write_beat(0, rand64());
        end
        @(posedge clk);
        assert (wr_full_o[0] === 1'b1 && wr_ready_o[0] === 1'b0) else begin
            errors++;
            $display("ERR %s: expected %0d, actual %0d", test_name, 1, wr_full_o[0]);
        end
        #1;
        read_addr(0);
        @(posedge clk);
        assert (wr_full_o[0] === 1'b0) else begin
            errors++;
            $display("ERR %s resume: expected %0d, actual %0d", test_name, 0, wr_full_o[0]);
        end
        #1;
        write_beat(0, rand64());
        repeat (16) read_addr(0);
        wait_drain();

        test_name = "empty";
        rd_addr_i[1]       = ADDR_W'(rd_addr[1]);
        rd_addr_valid_i[1] = 1'b1;
        repeat (3) begin
            @(posedge clk);
            assert (rd_empty_o[1] && !rd_addr_ready_o[1]) else begin
                errors++;
                $display("Read port 1 accepted an address that was not written yet");
            end
        end
        #1;
        write_beat(1, rand64());
        read_addr(1);
        wait_drain();

        test_name = "backpressure";
        rnd_ready = 1'b1;
        fork
            stream(0, 30);
            stream(1, 30);
        join
        wait_drain();
        rnd_ready = 1'b0;
        repeat (2) @(posedge clk);

        $display("Summary: %0d data checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
hw/glb_pkg.sv
hw/bank_sram.sv
hw/bank_port_select.sv
hw/wr_port_ctrl.sv
hw/rd_port_ctrl.sv
hw/glb_top.sv
testbench/tb_clk_gen.sv
testbench/glb_tb.sv

/* Bender.yml */
package:
  name: glb

sources:
  - hw/glb_pkg.sv
  - hw/bank_sram.sv
  - hw/bank_port_select.sv
  - hw/wr_port_ctrl.sv
  - hw/rd_port_ctrl.sv
  - hw/glb_top.sv
  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/glb_tb.sv
